// ==== logic/fb_pkg.sv ====
/*
 * fb_clut_display shared definitions
 * display timing, framebuffer geometry, colour widths and bus structs
 */
`default_nettype none

package fb_pkg;

    // coordinates
    localparam int CORDW = 16;                 // signed coordinate width
    typedef logic signed [CORDW-1:0] coord_t;

    // 640x480 timing, pixels and lines
    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BP     = 48;
    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 33;

    // colour
    localparam int CHANW     = 4;              // bits per channel
    localparam int COLRW     = 3 * CHANW;
    localparam int CIDXW     = 4;              // palette index
    localparam int PAL_DEPTH = 2 ** CIDXW;     // 16 entries
    localparam int OUTW      = 8;              // output channel width
    typedef logic [CIDXW-1:0] cidx_t;
    typedef struct packed {
        logic [CHANW-1:0] r;
        logic [CHANW-1:0] g;
        logic [CHANW-1:0] b;
    } colr_t;

    // framebuffer
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);  // 15 bits
    typedef logic [FB_ADDRW-1:0] fb_addr_t;

    // address, fb ram, palette ram
    localparam int SCAN_LAT = 3;

    // host register map
    localparam int REG_ADDRW = 5;
    localparam logic [REG_ADDRW-1:0] REG_BORDER = 5'd16;

    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   hsync;      // active low
        logic   vsync;      // active low
        logic   de;
        logic   frame;      // one cycle at start of period
    } disp_t;

    typedef struct packed {
        logic     we;
        fb_addr_t addr;
        cidx_t    cidx;
    } fb_wr_t;

    typedef struct packed {
        logic                 we;
        logic [REG_ADDRW-1:0] addr;  // 0..15 palette, 16 border
        colr_t                colr;
    } reg_wr_t;

    typedef struct packed {
        disp_t            disp;
        logic [OUTW-1:0]  r;
        logic [OUTW-1:0]  g;
        logic [OUTW-1:0]  b;
    } pix_out_t;

endpackage

`default_nettype wire

// ==== logic/display_timing.sv ====
/*
 * 640x480 display timing
 * signed coordinate counters with syncs, data enable and frame strobe
 */
`default_nettype none
`timescale 1ns/1ps

module display_timing
    import fb_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic rst_n,
    output disp_t     disp
);

    // horizontal positions, blanking is negative
    localparam coord_t H_STA  = coord_t'(-(H_FP + H_SYNC + H_BP));  // -160
    localparam coord_t HS_STA = coord_t'(-(H_SYNC + H_BP));         // sync start
    localparam coord_t HS_END = coord_t'(-H_BP);                    // first after sync
    localparam coord_t HA_END = coord_t'(H_ACTIVE - 1);

    // vertical positions
    localparam coord_t V_STA  = coord_t'(-(V_FP + V_SYNC + V_BP));  // -45
    localparam coord_t VS_STA = coord_t'(-(V_SYNC + V_BP));
    localparam coord_t VS_END = coord_t'(-V_BP);
    localparam coord_t VA_END = coord_t'(V_ACTIVE - 1);

    coord_t sx;
    coord_t sy;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= H_STA;  // start at top of blanking
            sy <= V_STA;
        end else if (sx == HA_END) begin  // end of line
            sx <= H_STA;
            if (sy == VA_END) begin
                sy <= V_STA;  // wrap to next frame
            end else begin
                sy <= sy + coord_t'(1);
            end
        end else begin
            sx <= sx + coord_t'(1);
        end
    end

    // everything decoded from the counters
    always_comb begin
        disp.sx    = sx;
        disp.sy    = sy;
        disp.hsync = ~(sx >= HS_STA && sx < HS_END);  // negative polarity
        disp.vsync = ~(sy >= VS_STA && sy < VS_END);
        disp.de    = (sx >= coord_t'(0) && sy >= coord_t'(0));
        disp.frame = (sx == H_STA && sy == V_STA);
    end

endmodule

`default_nettype wire

// ==== logic/bram_sdp.sv ====
/*
 * simple dual-port block RAM
 * one write port, one registered read port, payload set by type
 */
`default_nettype none
`timescale 1ns/1ps

module bram_sdp #(
    parameter int  DEPTH  = 16,
    parameter type data_t = logic [7:0]
) (
    input  wire logic                     clk_pix,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] addr_write,
    input  wire data_t                    data_in,
    input  wire logic [$clog2(DEPTH)-1:0] addr_read,
    output data_t                         data_out
);

    data_t mem [DEPTH];  // contents undefined until written

    // write port
    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk_pix) begin
        data_out <= mem[addr_read];
    end

endmodule

`default_nettype wire

// ==== logic/palette_regs.sv ====
/*
 * host register block
 * 16-entry palette RAM with lookup port, plus border colour register
 */
`default_nettype none
`timescale 1ns/1ps

module palette_regs
    import fb_pkg::*;
(
    input  wire logic    clk_pix,
    input  wire logic    rst_n,
    input  wire reg_wr_t reg_wr,
    input  wire cidx_t   cidx,     // lookup index from scanout
    output colr_t        colr,     // looked-up colour, next cycle
    output colr_t        border
);

    logic pal_we;
    logic border_we;

    // decode, addresses above 16 fall through
    always_comb begin
        pal_we    = reg_wr.we && !reg_wr.addr[REG_ADDRW-1];  // 0..15
        border_we = reg_wr.we && (reg_wr.addr == REG_BORDER);
    end

    bram_sdp #(
        .DEPTH  (PAL_DEPTH),
        .data_t (colr_t)
    ) palette_ram (
        .clk_pix    (clk_pix),
        .we         (pal_we),
        .addr_write (reg_wr.addr[CIDXW-1:0]),
        .data_in    (reg_wr.colr),
        .addr_read  (cidx),
        .data_out   (colr)
    );

    // border colour level
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            border <= '0;  // black
        end else if (border_we) begin
            border <= reg_wr.colr;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fb_scanout.sv ====
/*
 * framebuffer scanout
 * read-ahead address generation and registered colour output with border
 */
`default_nettype none
`timescale 1ns/1ps

module fb_scanout
    import fb_pkg::*;
(
    input  wire logic  clk_pix,
    input  wire logic  rst_n,
    input  wire disp_t disp,
    output fb_addr_t   fb_addr,
    input  wire colr_t colr,       // palette colour for current position
    input  wire colr_t border,
    output pix_out_t   pix_out
);

    // read window starts SCAN_LAT pixels before the painted area
    localparam coord_t RD_X_STA = coord_t'(-SCAN_LAT);
    localparam coord_t RD_X_END = coord_t'(FB_WIDTH - SCAN_LAT);
    localparam coord_t FB_X_END = coord_t'(FB_WIDTH);
    localparam coord_t FB_Y_END = coord_t'(FB_HEIGHT);

    logic  read_fb;     // address stage active
    logic  paint_area;  // current pixel inside framebuffer
    colr_t pix_colr;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            read_fb <= 1'b0;
            fb_addr <= '0;
        end else begin
            read_fb <= (disp.sy >= coord_t'(0) && disp.sy < FB_Y_END &&
                        disp.sx >= RD_X_STA && disp.sx < RD_X_END);
            if (disp.frame) begin
                fb_addr <= '0;  // back to first pixel each frame
            end else if (read_fb) begin
                fb_addr <= fb_addr + fb_addr_t'(1);
            end
        end
    end

    // pick the colour for this position
    always_comb begin
        paint_area = (disp.sy >= coord_t'(0) && disp.sy < FB_Y_END &&
                      disp.sx >= coord_t'(0) && disp.sx < FB_X_END);
        if (!disp.de) begin
            pix_colr = '0;  // blanking
        end else if (paint_area) begin
            pix_colr = colr;
        end else begin
            pix_colr = border;
        end
    end

    // output register, channels widened by repetition
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            pix_out            <= '0;
            pix_out.disp.hsync <= 1'b1;  // syncs idle high
            pix_out.disp.vsync <= 1'b1;
        end else begin
            pix_out.disp <= disp;
            pix_out.r    <= {(OUTW/CHANW){pix_colr.r}};
            pix_out.g    <= {(OUTW/CHANW){pix_colr.g}};
            pix_out.b    <= {(OUTW/CHANW){pix_colr.b}};
        end
    end

endmodule

`default_nettype wire

// ==== logic/fb_display_top.sv ====
/*
 * fb_clut_display top level
 * timing, framebuffer RAM, palette registers and scanout
 */
`default_nettype none
`timescale 1ns/1ps

module fb_display_top
    import fb_pkg::*;
(
    input  wire logic    clk_pix,
    input  wire logic    rst_n,
    input  wire fb_wr_t  fb_wr,    // host framebuffer write
    input  wire reg_wr_t reg_wr,   // host palette and border write
    output pix_out_t     pix_out
);

    disp_t    disp;
    fb_addr_t fb_addr;    // scanout read address
    cidx_t    fb_cidx;    // index from framebuffer
    colr_t    pal_colr;   // palette lookup result
    colr_t    border;

    display_timing timing_inst (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .disp    (disp)
    );

    bram_sdp #(
        .DEPTH  (FB_PIXELS),
        .data_t (cidx_t)
    ) fb_ram (
        .clk_pix    (clk_pix),
        .we         (fb_wr.we),
        .addr_write (fb_wr.addr),
        .data_in    (fb_wr.cidx),
        .addr_read  (fb_addr),
        .data_out   (fb_cidx)
    );

    palette_regs regs_inst (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .reg_wr  (reg_wr),
        .cidx    (fb_cidx),
        .colr    (pal_colr),
        .border  (border)
    );

    fb_scanout scanout_inst (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .disp    (disp),
        .fb_addr (fb_addr),
        .colr    (pal_colr),
        .border  (border),
        .pix_out (pix_out)
    );

endmodule

`default_nettype wire

// ==== verification/fb_display_assertions.sv ====
/*
 * scanout and timing assertions bound into fb_scanout
 */
`default_nettype none
`timescale 1ns/1ps

module fb_display_assertions
    import fb_pkg::*;
(
    input wire logic     clk_pix,
    input wire logic     rst_n,
    input wire disp_t    disp,
    input wire fb_addr_t fb_addr,
    input wire pix_out_t pix_out
);

    int fail_count = 0;  // failed assertions so far

    // frame strobe is a single pulse
    frame_one_cycle: assert property (@(posedge clk_pix) disable iff (!rst_n)
        disp.frame |=> !disp.frame)
        else begin
            fail_count++;
            $error("frame strobe high for more than one cycle");
        end

    // no reads below the framebuffer or right of it
    addr_holds: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (disp.sy >= coord_t'(FB_HEIGHT) || (disp.de && disp.sx >= coord_t'(FB_WIDTH)))
        |=> $stable(fb_addr))
        else begin
            fail_count++;
            $error("framebuffer address moved outside the read window");
        end

    blank_is_black: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !pix_out.disp.de |-> (pix_out.r == '0 && pix_out.g == '0 && pix_out.b == '0))
        else begin
            fail_count++;
            $error("colour not black while de is low");
        end

endmodule

`default_nettype wire

// ==== verification/fb_display_tb.sv ====
/*
 * fb_clut_display testbench
 * directed tests with a pixel-accurate reference model of the display
 */
`default_nettype none
`timescale 1ns/1ps

module fb_display_tb
    import fb_pkg::*;
();

    localparam int H_START      = -(H_FP + H_SYNC + H_BP);   // first blanking pixel
    localparam int V_START      = -(V_FP + V_SYNC + V_BP);
    localparam int HS_START     = H_START + H_FP;
    localparam int VS_START     = V_START + V_FP;
    localparam int H_TOTAL      = H_ACTIVE - H_START;
    localparam int FRAME_CYCLES = H_TOTAL * (V_ACTIVE - V_START);
    localparam int TIMEOUT      = 6 * FRAME_CYCLES + 20000;  // six frames plus margin
    localparam int MODE_PLAIN   = 0;
    localparam int MODE_BORDER  = 1;
    localparam int MODE_RECOLR  = 2;
    localparam int MODE_LIVE    = 3;

    logic     clk_pix;
    logic     rst_n;
    fb_wr_t   fb_wr;
    reg_wr_t  reg_wr;
    pix_out_t pix_out;

    cidx_t       fb_model [FB_PIXELS];  // host writes so far
    colr_t       pal_model [PAL_DEPTH];
    colr_t       border_model;
    int          exp_sx;                // position shown on pix_out
    int          exp_sy;
    int          cycle_count = 0;
    logic [15:0] lfsr_state;

    fb_display_top DUT (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .fb_wr   (fb_wr),
        .reg_wr  (reg_wr),
        .pix_out (pix_out)
    );

    bind fb_scanout fb_display_assertions scan_asserts (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .disp    (disp),
        .fb_addr (fb_addr),
        .pix_out (pix_out)
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;  // 4 ns period
    end

    always @(posedge clk_pix) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Errors found");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", TIMEOUT);
        end
    end

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_state[0]};  // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic step_pos();
        exp_sx++;
        if (exp_sx == H_ACTIVE) begin  // next line
            exp_sx = H_START;
            exp_sy = (exp_sy == V_ACTIVE - 1) ? V_START : exp_sy + 1;
        end
    endtask

    // expected output for the tracked position
    task automatic compare_pixel();
        logic  de;
        colr_t c;
        de = (exp_sx >= 0 && exp_sy >= 0);
        if (!de) begin
            c = '0;  // blanking is black
        end else if (exp_sx < FB_WIDTH && exp_sy < FB_HEIGHT) begin
            c = pal_model[fb_model[exp_sy * FB_WIDTH + exp_sx]];
        end else begin
            c = border_model;
        end
        check_value("sx", 32'($unsigned(pix_out.disp.sx)), 32'($unsigned(coord_t'(exp_sx))));
        check_value("sy", 32'($unsigned(pix_out.disp.sy)), 32'($unsigned(coord_t'(exp_sy))));
        check_value("de", 32'(pix_out.disp.de), 32'(de));
        check_value("hsync", 32'(pix_out.disp.hsync),
                    32'(!(exp_sx >= HS_START && exp_sx < HS_START + H_SYNC)));
        check_value("vsync", 32'(pix_out.disp.vsync),
                    32'(!(exp_sy >= VS_START && exp_sy < VS_START + V_SYNC)));
        check_value("frame", 32'(pix_out.disp.frame),
                    32'(exp_sx == H_START && exp_sy == V_START));
        check_value("r", 32'(pix_out.r), 32'({c.r, c.r}));  // doubled channels
        check_value("g", 32'(pix_out.g), 32'({c.g, c.g}));
        check_value("b", 32'(pix_out.b), 32'({c.b, c.b}));
    endtask

    task automatic wait_frame();
        do @(negedge clk_pix); while (!pix_out.disp.frame);
        exp_sx = H_START;
        exp_sy = V_START;
    endtask

    // host writes made while a frame is scanned
    task automatic drive_host(input int mode);
        fb_wr  = '0;
        reg_wr = '0;
        if (mode == MODE_BORDER && exp_sy == V_START && exp_sx == H_START) begin
            reg_wr       = '{we: 1'b1, addr: REG_BORDER, colr: 12'h3A5};
            border_model = 12'h3A5;
        end else if (mode == MODE_BORDER && exp_sy == V_START && exp_sx == H_START + 1) begin
            reg_wr = '{we: 1'b1, addr: 5'd20, colr: 12'hFFF};  // unmapped
        end else if (mode == MODE_RECOLR && exp_sy == V_START &&
                     exp_sx < H_START + PAL_DEPTH) begin
            reg_wr.we   = 1'b1;
            reg_wr.addr = 5'(exp_sx - H_START);
            reg_wr.colr = colr_t'(rand_bits(COLRW));
            pal_model[exp_sx - H_START] = reg_wr.colr;
        end else if (mode == MODE_LIVE && exp_sy == 10 && exp_sx >= 0 && exp_sx < FB_WIDTH) begin
            fb_wr.we   = 1'b1;
            fb_wr.addr = fb_addr_t'(100 * FB_WIDTH + exp_sx);  // row 100 is read later
            fb_wr.cidx = cidx_t'(rand_bits(CIDXW));
            fb_model[100 * FB_WIDTH + exp_sx] = fb_wr.cidx;
        end
    endtask

    // checks every pixel of one frame from the frame strobe on
    task automatic run_frame(input int mode);
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            compare_pixel();
            drive_host(mode);
            @(negedge clk_pix);
            step_pos();
        end
        fb_wr  = '0;
        reg_wr = '0;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(negedge clk_pix);
        check_value("reset de", 32'(pix_out.disp.de), 32'd0);
        check_value("reset hsync", 32'(pix_out.disp.hsync), 32'd1);  // idle high
        check_value("reset vsync", 32'(pix_out.disp.vsync), 32'd1);
        check_value("reset colour", 32'({pix_out.r, pix_out.g, pix_out.b}), 32'd0);
        rst_n = 1'b1;
    endtask

    task automatic measure_frame_timing();
        int cycles;
        int de_cnt;
        int hs_cnt;
        cycles = 0;
        de_cnt = 0;
        hs_cnt = 0;
        wait_frame();
        do begin
            de_cnt += int'(pix_out.disp.de);
            hs_cnt += int'(!pix_out.disp.hsync);
            cycles++;
            if (cycles % H_TOTAL == 0) begin  // end of a line
                check_value("hsync low per line", 32'(hs_cnt), 32'(H_SYNC));
                hs_cnt = 0;
            end
            @(negedge clk_pix);
        end while (!pix_out.disp.frame);
        check_value("frame cycles", 32'(cycles), 32'(FRAME_CYCLES));
        check_value("de cycles", 32'(de_cnt), 32'(H_ACTIVE * V_ACTIVE));
    endtask

    task automatic fill_and_scan_image();
        for (int i = 0; i < FB_PIXELS; i++) begin
            fb_wr = '{we: 1'b1, addr: fb_addr_t'(i), cidx: cidx_t'(rand_bits(CIDXW))};
            fb_model[i] = fb_wr.cidx;
            reg_wr = '0;
            if (i < PAL_DEPTH) begin  // palette alongside the first writes
                reg_wr = '{we: 1'b1, addr: 5'(i), colr: colr_t'(rand_bits(COLRW))};
                pal_model[i] = reg_wr.colr;
            end
            @(negedge clk_pix);
        end
        fb_wr  = '0;
        reg_wr = '0;
        wait_frame();
        run_frame(MODE_PLAIN);
    endtask

    initial begin
        fb_wr        = '0;
        reg_wr       = '0;
        rst_n        = 1'b0;
        lfsr_state   = 16'd84;
        border_model = '0;  // border resets to black
        apply_reset();
        measure_frame_timing();
        fill_and_scan_image();
        run_frame(MODE_BORDER);  // border plus ignored address 20
        run_frame(MODE_RECOLR);  // new palette in vertical blanking
        run_frame(MODE_LIVE);    // row 100 rewritten during row 10
        if (DUT.scanout_inst.scan_asserts.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "the run ended with failed checks");
        end
    end

endmodule

`default_nettype wire

// ==== fb_clut_display.f ====
logic/fb_pkg.sv
logic/display_timing.sv
logic/bram_sdp.sv
logic/palette_regs.sv
logic/fb_scanout.sv
logic/fb_display_top.sv
verification/fb_display_assertions.sv
verification/fb_display_tb.sv

// ==== Makefile ====
# Verilator build and run for fb_clut_display

TOP := fb_display_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f fb_clut_display.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
